/* tb.f */
verilog/icache_pkg.sv
verilog/icache_req_stage.sv
verilog/icache_ways.sv
verilog/icache_ctrl.sv
verilog/icache_fetch_out.sv
verilog/icache_top.sv
test/tb_mem_model.sv
test/tb_icache.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= tb.f
TB_TOP    ?= tb_icache
RTL_TOP   ?= icache_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

RTL_SRCS  := $(filter verilog/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TB_TOP)
	./$(OBJ_DIR)/$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;

    localparam int INDEX_WIDTH = 6;
    localparam int MAX_CYCLES  = 2000;   // 14 fetches of at most ~14 cycles, wide margin

    logic                             clk = 1'b0;
    logic                             rstn;
    logic                             i_rvalid;
    icache_pkg::fetch_addr_t          i_raddr;
    logic                             i_flush;
    logic                             i_mem_rready;
    logic [icache_pkg::LINE_BITS-1:0] i_mem_rdata;
    logic                             o_rready;
    icache_pkg::fetch_resp_t          o_resp;
    logic                             o_idle;
    icache_pkg::mem_req_t             o_mem_req;

    logic [31:0] exp_pc     = '0;     // fetch in flight
    logic        exp_miss   = 1'b0;
    logic        live       = 1'b0;   // its response still wanted
    logic        started    = 1'b0;
    int unsigned cycles     = 0;
    int unsigned resp_count = 0;
    int unsigned since_cap  = 0;      // edges since the capture edge
    logic        saw_mem    = 1'b0;

    icache_top #(.INDEX_WIDTH(INDEX_WIDTH)) u_dut (.*);

    tb_mem_model u_mem (
        .clk      (clk),
        .rstn     (rstn),
        .i_req    (o_mem_req),
        .o_rready (i_mem_rready),
        .o_rdata  (i_mem_rdata)
    );

    always #2 clk = ~clk;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "run stopped at the first failure");
    endtask

    // expected pair, two words of the memory rule at pc with bits 2:0 cleared
    function automatic logic [63:0] pair_at(input logic [31:0] pc);
        logic [31:0] lo;
        lo = {pc[31:3], 3'b000};
        return {(lo + 32'd4) ^ 32'h5a5a_0000, lo ^ 32'h5a5a_0000};
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (o_rready) resp_count <= resp_count + 1;
        if (i_rvalid && o_idle && !i_flush) begin   // capture edge
            since_cap <= 1;
            saw_mem   <= 1'b0;
        end else begin
            since_cap <= since_cap + 1;
            saw_mem   <= saw_mem | o_mem_req.valid;
        end
        if (cycles == MAX_CYCLES) fail_now("timeout: the run did not finish within the cycle limit");
    end

    assert property (@(posedge clk) disable iff (!rstn) !started |-> o_idle && !o_mem_req.valid)
        else fail_now("cache left idle or asked memory before the first fetch");
    assert property (@(posedge clk) disable iff (!rstn) o_rready |-> live)
        else fail_now("o_rready pulsed with no fetch waiting for a response");
    assert property (@(posedge clk) disable iff (!rstn) o_rready |-> o_resp.pc == exp_pc)
        else fail_now($sformatf("MISMATCH %0t o_resp.pc got %h expected %h",
                                $time, $sampled(o_resp.pc), exp_pc));
    assert property (@(posedge clk) disable iff (!rstn)
                     o_rready |-> o_resp.adef == (exp_pc[1:0] != 2'b00))
        else fail_now($sformatf("MISMATCH %0t o_resp.adef got %b expected %b",
                                $time, $sampled(o_resp.adef), exp_pc[1:0] != 2'b00));
    assert property (@(posedge clk) disable iff (!rstn)
                     o_rready && !o_resp.adef |-> o_resp.data == pair_at(exp_pc))
        else fail_now($sformatf("MISMATCH %0t o_resp.data got %h expected %h",
                                $time, $sampled(o_resp.data), pair_at(exp_pc)));
    // hits and bad pcs never go to memory
    assert property (@(posedge clk) disable iff (!rstn) o_mem_req.valid |-> exp_miss)
        else fail_now("memory request for a fetch that should hit or is misaligned");
    assert property (@(posedge clk) disable iff (!rstn)
                     o_mem_req.valid |-> o_mem_req.addr == {exp_pc[31:6], 6'd0})
        else fail_now($sformatf("MISMATCH %0t o_mem_req.addr got %h expected %h",
                                $time, $sampled(o_mem_req.addr), {exp_pc[31:6], 6'd0}));
    assert property (@(posedge clk) disable iff (!rstn)
                     o_rready && !exp_miss |-> since_cap == 1)
        else fail_now($sformatf("MISMATCH %0t o_rready latency got %0d expected 1",
                                $time, $sampled(since_cap)));
    assert property (@(posedge clk) disable iff (!rstn) o_rready && exp_miss |-> saw_mem)
        else fail_now("fetch expected to miss was answered without a memory request");

    // one fetch, rvalid held for the capture cycle only
    task automatic fetch(input logic [31:0] addr, input logic miss, input logic cancel);
        int unsigned start;
        @(negedge clk);
        while (!o_idle) @(negedge clk);
        start    = resp_count;
        exp_pc   = addr;
        exp_miss = miss;
        live     = 1'b1;
        started  = 1'b1;
        i_rvalid = 1'b1;
        i_raddr  = addr;
        @(negedge clk);
        i_rvalid = 1'b0;
        if (cancel) begin
            while (!o_mem_req.valid) @(negedge clk);
            live    = 1'b0;   // flush while the line is on its way
            i_flush = 1'b1;
            @(negedge clk);
            i_flush = 1'b0;
            while (!o_idle) @(negedge clk);
        end else begin
            while (resp_count == start) @(negedge clk);
            live = 1'b0;
        end
    endtask

    initial begin
        rstn     = 1'b0;
        i_rvalid = 1'b0;
        i_raddr  = '0;
        i_flush  = 1'b0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        repeat (4) @(negedge clk);
        fetch(32'h0000_1048, 1'b1, 1'b0);   // line A in set 1, cold miss
        fetch(32'h0000_1078, 1'b0, 1'b0);   // last pair of A
        fetch(32'h0000_1044, 1'b0, 1'b0);   // upper word, pair starts at 1040
        fetch(32'h0000_1046, 1'b0, 1'b0);   // misaligned in a cached line
        fetch(32'h0000_5101, 1'b0, 1'b0);   // misaligned, line never fetched
        // A, B, A, C in set 1 so C evicts B
        fetch(32'h0000_2040, 1'b1, 1'b0);
        fetch(32'h0000_1050, 1'b0, 1'b0);
        fetch(32'h0000_3060, 1'b1, 1'b0);
        fetch(32'h0000_1058, 1'b0, 1'b0);
        fetch(32'h0000_2070, 1'b1, 1'b0);
        fetch(32'h0000_7080, 1'b1, 1'b1);   // flushed in MISS
        fetch(32'h0000_70b8, 1'b0, 1'b0);   // refill still landed
        fetch(32'hdead_be80, 1'b1, 1'b0);
        fetch(32'hdead_bebc, 1'b0, 1'b0);
        repeat (4) @(negedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

/* test/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model #(
    parameter logic [31:0] SEED = 32'hdd2e26a9
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  icache_pkg::mem_req_t             i_req,
    output logic                             o_rready,
    output logic [icache_pkg::LINE_BITS-1:0] o_rdata
);

    // one line request at a time, answered after 1 to 8 cycles
    logic                             rready_q  = 1'b0;
    logic [icache_pkg::LINE_BITS-1:0] rdata_q   = '0;
    logic                             busy      = 1'b0;
    logic [2:0]                       wait_left = '0;
    logic [31:0]                      base      = '0;
    logic [31:0]                      rng       = SEED;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word k holds its own byte address xor 5a5a0000
    function automatic logic [icache_pkg::LINE_BITS-1:0] line_at(input logic [31:0] addr);
        logic [icache_pkg::LINE_BITS-1:0] words;
        for (int k = 0; k < icache_pkg::LINE_BITS / 32; k++) begin
            words[32*k +: 32] = (addr + 32'(4 * k)) ^ 32'h5a5a_0000;
        end
        return words;
    endfunction

    always @(negedge clk) begin
        if (!rstn) begin
            rready_q <= 1'b0;
            busy     <= 1'b0;
        end else if (rready_q) begin
            rready_q <= 1'b0;   // strobe lasts one cycle
            busy     <= 1'b0;
        end else if (busy) begin
            if (wait_left == 3'd0) begin
                rready_q <= 1'b1;
                rdata_q  <= line_at(base);
            end else begin
                wait_left <= wait_left - 3'd1;
            end
        end else if (i_req.valid) begin
            busy      <= 1'b1;
            base      <= i_req.addr;
            wait_left <= rng[2:0];   // extra wait, 0 to 7
            rng       <= xorshift(rng);
        end
    end

    assign o_rready = rready_q;
    assign o_rdata  = rdata_q;

endmodule

/* verilog/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             i_rvalid,
    input  icache_pkg::fetch_addr_t          i_raddr,
    input  logic                             i_flush,
    input  logic                             i_mem_rready,
    input  logic [icache_pkg::LINE_BITS-1:0] i_mem_rdata,
    output logic                             o_rready,
    output icache_pkg::fetch_resp_t          o_resp,
    output logic                             o_idle,
    output icache_pkg::mem_req_t             o_mem_req
);

    icache_pkg::fetch_addr_t          req_addr;
    logic                             resp_ok;
    logic                             adef;
    logic                             capture;
    logic                             miss;
    logic [1:0]                       way_we;
    logic                             lru_we;
    logic                             lru_way;
    logic                             respond;
    logic                             from_refill;
    logic                             hit;
    logic                             hit_way;
    logic [icache_pkg::LINE_BITS-1:0] hit_line;
    logic                             victim_way;
    logic [icache_pkg::LINE_BITS-1:0] refill_line;

    icache_req_stage #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_req_stage (
        .clk        (clk),
        .rstn       (rstn),
        .i_raddr    (i_raddr),
        .i_rvalid   (i_rvalid),
        .i_capture  (capture),
        .i_flush    (i_flush),
        .o_req_addr (req_addr),
        .o_resp_ok  (resp_ok),
        .o_adef     (adef)
    );

    icache_ways #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_ways (
        .clk           (clk),
        .rstn          (rstn),
        .i_raddr       (i_raddr),
        .i_req_addr    (req_addr),
        .i_refill_line (refill_line),
        .i_way_we      (way_we),
        .i_lru_we      (lru_we),
        .i_lru_way     (lru_way),
        .o_hit         (hit),
        .o_hit_way     (hit_way),
        .o_hit_line    (hit_line),
        .o_victim_way  (victim_way)
    );

    icache_ctrl u_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .i_rvalid      (i_rvalid),
        .i_flush       (i_flush),
        .i_adef        (adef),
        .i_hit         (hit),
        .i_hit_way     (hit_way),
        .i_victim_way  (victim_way),
        .i_mem_rready  (i_mem_rready),
        .o_capture     (capture),
        .o_miss        (miss),
        .o_way_we      (way_we),
        .o_lru_we      (lru_we),
        .o_lru_way     (lru_way),
        .o_respond     (respond),
        .o_from_refill (from_refill),
        .o_idle        (o_idle)
    );

    icache_fetch_out #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_fetch_out (
        .clk           (clk),
        .rstn          (rstn),
        .i_req_addr    (req_addr),
        .i_miss        (miss),
        .i_mem_rready  (i_mem_rready),
        .i_mem_rdata   (i_mem_rdata),
        .i_hit_line    (hit_line),
        .i_from_refill (from_refill),
        .i_respond     (respond),
        .i_resp_ok     (resp_ok),
        .i_adef        (adef),
        .o_mem_req     (o_mem_req),
        .o_refill_line (refill_line),
        .o_rready      (o_rready),
        .o_resp        (o_resp)
    );

endmodule

/* verilog/icache_fetch_out.sv */
`timescale 1ns/1ps

module icache_fetch_out #(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  icache_pkg::fetch_addr_t          i_req_addr,
    input  logic                             i_miss,
    input  logic                             i_mem_rready,
    input  logic [icache_pkg::LINE_BITS-1:0] i_mem_rdata,
    input  logic [icache_pkg::LINE_BITS-1:0] i_hit_line,
    input  logic                             i_from_refill,
    input  logic                             i_respond,
    input  logic                             i_resp_ok,
    input  logic                             i_adef,
    output icache_pkg::mem_req_t             o_mem_req,
    output logic [icache_pkg::LINE_BITS-1:0] o_refill_line,
    output logic                             o_rready,
    output icache_pkg::fetch_resp_t          o_resp
);

    localparam int TAG_WIDTH = icache_pkg::LINE_ADDR_BITS - INDEX_WIDTH;

    logic [icache_pkg::LINE_BITS-1:0]  ret_buf;    // line returned by memory
    logic [icache_pkg::LINE_BITS-1:0]  src_line;
    logic [TAG_WIDTH-1:0]              req_tag;
    logic [INDEX_WIDTH-1:0]            req_index;

    assign req_tag   = i_req_addr.line_addr[icache_pkg::LINE_ADDR_BITS-1:INDEX_WIDTH];
    assign req_index = i_req_addr.line_addr[INDEX_WIDTH-1:0];

    // line-aligned request, held for the whole miss
    assign o_mem_req.valid = i_miss;
    assign o_mem_req.addr  = {req_tag, req_index, {icache_pkg::OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ret_buf <= '0;
        end else if (i_miss && i_mem_rready) begin
            ret_buf <= i_mem_rdata;
        end
    end

    assign o_refill_line = ret_buf;

    // pair select, bits 5:3 of the pc
    assign src_line = i_from_refill ? ret_buf : i_hit_line;

    assign o_resp.data = src_line[i_req_addr.pair * icache_pkg::FETCH_BITS +:
                                  icache_pkg::FETCH_BITS];
    assign o_resp.pc   = i_req_addr;
    assign o_resp.adef = i_adef;

    // a flushed request still finishes inside but is never reported
    assign o_rready = i_respond & i_resp_ok;

endmodule

/* verilog/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl (
    input  logic       clk,
    input  logic       rstn,
    input  logic       i_rvalid,
    input  logic       i_flush,
    input  logic       i_adef,
    input  logic       i_hit,
    input  logic       i_hit_way,
    input  logic       i_victim_way,
    input  logic       i_mem_rready,
    output logic       o_capture,
    output logic       o_miss,
    output logic [1:0] o_way_we,
    output logic       o_lru_we,
    output logic       o_lru_way,
    output logic       o_respond,
    output logic       o_from_refill,
    output logic       o_idle
);

    icache_pkg::ctrl_state_t state;
    icache_pkg::ctrl_state_t next_state;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= icache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state    = state;
        o_capture     = 1'b0;
        o_miss        = 1'b0;
        o_way_we      = 2'b00;
        o_lru_we      = 1'b0;
        o_lru_way     = 1'b0;
        o_respond     = 1'b0;
        o_from_refill = 1'b0;

        case (state)
            icache_pkg::IDLE: begin
                o_capture = 1'b1;   // buffer follows the pipeline while idle
                if (i_rvalid && !i_flush) begin
                    next_state = icache_pkg::LOOKUP;
                end
            end

            icache_pkg::LOOKUP: begin
                if (i_flush) begin
                    next_state = icache_pkg::IDLE;
                end else if (i_adef) begin
                    o_respond  = 1'b1;   // no memory access for a bad pc
                    next_state = icache_pkg::IDLE;
                end else if (i_hit) begin
                    o_respond  = 1'b1;
                    o_lru_we   = 1'b1;
                    o_lru_way  = i_hit_way;
                    // next fetch taken right away, one response per cycle
                    o_capture  = i_rvalid;
                    next_state = i_rvalid ? icache_pkg::LOOKUP : icache_pkg::IDLE;
                end else begin
                    next_state = icache_pkg::MISS;
                end
            end

            icache_pkg::MISS: begin
                o_miss = 1'b1;
                if (i_mem_rready) begin
                    next_state = icache_pkg::REFILL;
                end
            end

            icache_pkg::REFILL: begin
                // line goes into the victim way, which becomes most recent
                o_way_we      = {i_victim_way, ~i_victim_way};
                o_lru_we      = 1'b1;
                o_lru_way     = i_victim_way;
                o_respond     = 1'b1;
                o_from_refill = 1'b1;
                o_capture     = i_rvalid && !i_flush;
                next_state    = (i_rvalid && !i_flush) ? icache_pkg::LOOKUP
                                                       : icache_pkg::IDLE;
            end

            default: begin
                next_state = icache_pkg::IDLE;
            end
        endcase
    end

    assign o_idle = (state == icache_pkg::IDLE);

endmodule

/* verilog/icache_ways.sv */
`timescale 1ns/1ps

module icache_ways #(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  icache_pkg::fetch_addr_t          i_raddr,
    input  icache_pkg::fetch_addr_t          i_req_addr,
    input  logic [icache_pkg::LINE_BITS-1:0] i_refill_line,
    input  logic [1:0]                       i_way_we,
    input  logic                             i_lru_we,
    input  logic                             i_lru_way,
    output logic                             o_hit,
    output logic                             o_hit_way,
    output logic [icache_pkg::LINE_BITS-1:0] o_hit_line,
    output logic                             o_victim_way
);

    localparam int TAG_WIDTH = icache_pkg::LINE_ADDR_BITS - INDEX_WIDTH;
    localparam int SETS      = 1 << INDEX_WIDTH;

    // storage, one row per set and way
    logic [TAG_WIDTH-1:0]             tag_mem  [2][SETS];
    logic [icache_pkg::LINE_BITS-1:0] data_mem [2][SETS];
    logic [1:0][SETS-1:0]             valid;
    logic [SETS-1:0]                  lru;        // last used way per set

    // read port outputs, one cycle after i_raddr
    logic [1:0]                       rd_valid;
    logic [TAG_WIDTH-1:0]             rd_tag  [2];
    logic [icache_pkg::LINE_BITS-1:0] rd_line [2];

    logic [INDEX_WIDTH-1:0] r_index;
    logic [INDEX_WIDTH-1:0] w_index;
    logic [TAG_WIDTH-1:0]   req_tag;
    logic                   same_set;
    logic [1:0]             hit;

    assign r_index  = i_raddr.line_addr[INDEX_WIDTH-1:0];
    assign w_index  = i_req_addr.line_addr[INDEX_WIDTH-1:0];
    assign req_tag  = i_req_addr.line_addr[icache_pkg::LINE_ADDR_BITS-1:INDEX_WIDTH];
    assign same_set = (w_index == r_index);

    // tag and data arrays, a read of the set being refilled sees the new line
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (i_way_we[w]) begin
                tag_mem[w][w_index]  <= req_tag;
                data_mem[w][w_index] <= i_refill_line;
            end
            if (i_way_we[w] && same_set) begin
                rd_tag[w]  <= req_tag;
                rd_line[w] <= i_refill_line;
            end else begin
                rd_tag[w]  <= tag_mem[w][r_index];
                rd_line[w] <= data_mem[w][r_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid    <= '0;
            rd_valid <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (i_way_we[w]) begin
                    valid[w][w_index] <= 1'b1;
                end
                rd_valid[w] <= valid[w][r_index] | (i_way_we[w] & same_set);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru <= '0;
        end else if (i_lru_we) begin
            lru[w_index] <= i_lru_way;
        end
    end

    // compare against the captured request
    assign hit[0] = rd_valid[0] && (rd_tag[0] == req_tag);
    assign hit[1] = rd_valid[1] && (rd_tag[1] == req_tag);

    assign o_hit        = |hit;
    assign o_hit_way    = hit[1];
    assign o_hit_line   = hit[1] ? rd_line[1] : rd_line[0];
    assign o_victim_way = ~lru[w_index];   // the way not used last

endmodule

/* verilog/icache_req_stage.sv */
`timescale 1ns/1ps

module icache_req_stage #(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  icache_pkg::fetch_addr_t i_raddr,
    input  logic                    i_rvalid,
    input  logic                    i_capture,
    input  logic                    i_flush,
    output icache_pkg::fetch_addr_t o_req_addr,
    output logic                    o_resp_ok,
    output logic                    o_adef
);

    localparam int TAG_WIDTH = icache_pkg::LINE_ADDR_BITS - INDEX_WIDTH;

    // request buffer, tag and set kept apart
    logic [TAG_WIDTH-1:0]                req_tag;
    logic [INDEX_WIDTH-1:0]              req_index;
    logic [icache_pkg::PAIR_BITS-1:0]    req_pair;
    logic [icache_pkg::BYTE_SEL_BITS-1:0] req_byte;
    logic                                 flush_valid;

    always_ff @(posedge clk) begin
        if (i_capture) begin
            req_tag   <= i_raddr.line_addr[icache_pkg::LINE_ADDR_BITS-1:INDEX_WIDTH];
            req_index <= i_raddr.line_addr[INDEX_WIDTH-1:0];
            req_pair  <= i_raddr.pair;
            req_byte  <= i_raddr.byte_sel;
        end
    end

    // flush wins over a capture in the same cycle
    always_ff @(posedge clk) begin
        if (!rstn || i_flush) begin
            flush_valid <= 1'b0;
        end else if (i_capture) begin
            flush_valid <= i_rvalid;
        end
    end

    assign o_req_addr.line_addr = {req_tag, req_index};
    assign o_req_addr.pair      = req_pair;
    assign o_req_addr.byte_sel  = req_byte;

    assign o_resp_ok = flush_valid;
    assign o_adef    = |req_byte[1:0];   // fetches must be word aligned

endmodule

/* verilog/icache_pkg.sv */
package icache_pkg;

    // line geometry
    localparam int LINE_BITS      = 512;
    localparam int FETCH_BITS     = 64;    // two instructions per fetch
    localparam int OFFSET_BITS    = 6;
    localparam int ADDR_BITS      = 32;
    localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;
    localparam int PAIR_BITS      = 3;     // pair number inside a line
    localparam int BYTE_SEL_BITS  = OFFSET_BITS - PAIR_BITS;

    // fetch address split, tag and set are cut from line_addr
    // by each module once it knows INDEX_WIDTH
    typedef struct packed {
        logic [LINE_ADDR_BITS-1:0] line_addr;
        logic [PAIR_BITS-1:0]      pair;
        logic [BYTE_SEL_BITS-1:0]  byte_sel;
    } fetch_addr_t;

    // back to the pipeline with the o_rready strobe
    typedef struct packed {
        logic [FETCH_BITS-1:0] data;
        logic [ADDR_BITS-1:0]  pc;
        logic                  adef;   // pc not word aligned
    } fetch_resp_t;

    // whole line request, held until memory answers
    typedef struct packed {
        logic                 valid;
        logic [ADDR_BITS-1:0] addr;
    } mem_req_t;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        LOOKUP = 2'd1,
        MISS   = 2'd2,
        REFILL = 2'd3
    } ctrl_state_t;

endpackage
